/* include/pat_defs.svh */
`ifndef PAT_DEFS_SVH
`define PAT_DEFS_SVH

// ====================================================================
// widths
// ====================================================================
`define PAT_D_WIDTH      8    // data word
`define PAT_I_WIDTH      23   // instruction word
`define PAT_I_ADR_WIDTH  10   // program counter
`define PAT_R_ADR_WIDTH  3    // register number, eight entries
`define PAT_OP_WIDTH     4    // each of the three opcode spaces

// ====================================================================
// opcodes, all-ones escapes to the next space
// ====================================================================
`define PAT_PREFIX       4'hf
// i8 space
`define PAT_OP_ORI       4'd0
`define PAT_OP_ORR       4'd1
`define PAT_OP_ANDI      4'd2
`define PAT_OP_ANDR      4'd3
`define PAT_OP_ADDI      4'd4
`define PAT_OP_ADDR      4'd5
`define PAT_OP_SUBI      4'd6
`define PAT_OP_SUBR      4'd7
`define PAT_OP_LDI       4'd8
`define PAT_OP_BF        4'd13
`define PAT_OP_CALL      4'd14
// i3 space, taken from imm8[7:4]
`define PAT_OP_SHLZI     4'd0
`define PAT_OP_SHLZR     4'd1
`define PAT_OP_SHLOI     4'd2
`define PAT_OP_SHLOR     4'd3
`define PAT_OP_SHRZI     4'd4
`define PAT_OP_SHRZR     4'd5
`define PAT_OP_ASRI      4'd6
`define PAT_OP_ASRR      4'd7
`define PAT_OP_IN        4'd8
`define PAT_OP_OUT       4'd11
// i0 space, taken from imm8[3:0]
`define PAT_OP_NOT       4'd0
`define PAT_OP_TEST      4'd2
`define PAT_OP_RETURN    4'd3
`define PAT_OP_NOP       4'd15

`define PAT_COND_Z       2'd0   // zero flag set
`define PAT_COND_NZ      2'd1   // zero flag clear
`define PAT_COND_N       2'd2   // negative flag set
`define PAT_COND_AL      2'd3   // always

`define PAT_INSTR_NOP    23'h006fff   // i0 nop, cond AL
`define PAT_JUMP_SHADOW  3      // slots squashed after a taken jump
`define PAT_CALL_ADJUST  2      // pc at load time minus this is the return address

`endif

/* hw/pat_pkg.sv */
`include "pat_defs.svh"

package pat_pkg;

	// ================================================================
	// shared word types
	// ================================================================
	typedef logic [`PAT_D_WIDTH-1:0]     data_t;   // register and port data
	typedef logic [`PAT_I_ADR_WIDTH-1:0] iaddr_t;  // instruction address
	typedef logic [`PAT_I_WIDTH-1:0]     instr_t;  // raw instruction word
	typedef logic [`PAT_R_ADR_WIDTH-1:0] radr_t;   // register number

	// one alu operation per decoded instruction
	typedef enum logic [3:0]
	{
		ALU_OR,      // ori, orr
		ALU_AND,     // andi, andr
		ALU_ADD,     // addi, addr
		ALU_SUB,     // subi, subr
		ALU_NOT,     // complement of a
		ALU_SHLZ,    // left, zero fill
		ALU_SHLO,    // left, one fill
		ALU_SHRZ,    // right, zero fill
		ALU_ASR,     // right, one fill from the top
		ALU_PASS_B   // ldi, in, and ops that write nothing
	} alu_op_t;

endpackage

/* hw/pat_decode.sv */
`timescale 1ns/10ps
`include "pat_defs.svh"

module pat_decode
(
	input  logic               clk,
	input  logic               reset,
	input  pat_pkg::instr_t    i_instruction,
	input  pat_pkg::data_t     i_in0,
	input  pat_pkg::data_t     i_in1,
	input  pat_pkg::data_t     i_in2,
	input  pat_pkg::data_t     i_rd_a,        // R[Rn]
	input  pat_pkg::data_t     i_rd_b,        // R[imm3]
	output pat_pkg::radr_t     o_rd_adr_a,
	output pat_pkg::radr_t     o_rd_adr_b,
	output pat_pkg::alu_op_t   o_alu_op,
	output pat_pkg::data_t     o_a,
	output pat_pkg::data_t     o_b,
	output pat_pkg::radr_t     o_rd,
	output logic [1:0]         o_cond,
	output logic               o_wr,
	output logic               o_out,
	output logic               o_test,
	output logic               o_bf,
	output logic               o_call,
	output logic               o_ret,
	output pat_pkg::data_t     o_offset       // branch distance, raw imm8
);

	pat_pkg::instr_t           instr_q;       // E0 capture
	pat_pkg::radr_t            rn;
	logic [1:0]                cond;
	logic [`PAT_OP_WIDTH-1:0]  opc8, opc3, opc0;
	pat_pkg::data_t            imm8;
	logic [2:0]                imm3;
	logic                      t_i8, t_i3, t_i0;
	logic                      op_alu8, op_shift, op_in, op_not;
	logic                      src_imm;
	pat_pkg::alu_op_t          alu_op;
	pat_pkg::data_t            imm_val, in_sel, b_sel;

	// Rn | reserved 5 | cond | reserved | i8 op | imm8
	assign rn   = instr_q[22:20];
	assign cond = instr_q[14:13];
	assign opc8 = instr_q[11:8];
	assign imm8 = instr_q[7:0];
	assign opc3 = imm8[7:4];   // nested spaces live in imm8
	assign opc0 = imm8[3:0];
	assign imm3 = imm8[2:0];

	assign t_i8 = (opc8 != `PAT_PREFIX);
	assign t_i3 = (opc8 == `PAT_PREFIX) && (opc3 != `PAT_PREFIX);
	assign t_i0 = !t_i8 && !t_i3;

	assign op_alu8  = t_i8 && (opc8 <= `PAT_OP_LDI);   // or/and/add/sub pairs and ldi
	assign op_shift = t_i3 && !opc3[3];                // codes 0..7
	assign op_in    = t_i3 && (opc3 == `PAT_OP_IN);
	assign op_not   = t_i0 && (opc0 == `PAT_OP_NOT);
	// even codes take the immediate, odd ones the second register
	assign src_imm  = (t_i8 && !opc8[0]) || (op_shift && !opc3[0]);

	always_comb
	begin
		alu_op = pat_pkg::ALU_PASS_B;   // ldi, in, non-writing ops
		if (t_i8)
		begin
			case (opc8)
				`PAT_OP_ORI, `PAT_OP_ORR:   alu_op = pat_pkg::ALU_OR;
				`PAT_OP_ANDI, `PAT_OP_ANDR: alu_op = pat_pkg::ALU_AND;
				`PAT_OP_ADDI, `PAT_OP_ADDR: alu_op = pat_pkg::ALU_ADD;
				`PAT_OP_SUBI, `PAT_OP_SUBR: alu_op = pat_pkg::ALU_SUB;
				default:                    alu_op = pat_pkg::ALU_PASS_B;
			endcase
		end
		else if (t_i3)
		begin
			case (opc3)
				`PAT_OP_SHLZI, `PAT_OP_SHLZR: alu_op = pat_pkg::ALU_SHLZ;
				`PAT_OP_SHLOI, `PAT_OP_SHLOR: alu_op = pat_pkg::ALU_SHLO;
				`PAT_OP_SHRZI, `PAT_OP_SHRZR: alu_op = pat_pkg::ALU_SHRZ;
				`PAT_OP_ASRI, `PAT_OP_ASRR:   alu_op = pat_pkg::ALU_ASR;
				default:                      alu_op = pat_pkg::ALU_PASS_B;
			endcase
		end
		else if (op_not)
			alu_op = pat_pkg::ALU_NOT;
	end

	// input port pick, unlisted codes fall back to port 0
	always_comb
	begin
		case (imm3)
			3'd2:    in_sel = i_in1;
			3'd4:    in_sel = i_in2;
			default: in_sel = i_in0;
		endcase
	end

	assign imm_val = t_i8 ? imm8 : {5'b0, imm3};   // i3 shift amount sits in bits 1..0
	assign b_sel   = op_in ? in_sel : (src_imm ? imm_val : i_rd_b);

	assign o_rd_adr_a = rn;
	assign o_rd_adr_b = imm3;   // same bits as imm8[2:0] for i8 register forms

	// ================================================================
	// E0 capture and E1 decode registers
	// ================================================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			instr_q <= `PAT_INSTR_NOP;
			o_wr    <= 1'b0;
			o_out   <= 1'b0;
			o_test  <= 1'b0;
			o_bf    <= 1'b0;
			o_call  <= 1'b0;
			o_ret   <= 1'b0;
		end
		else
		begin
			instr_q <= i_instruction;
			o_wr    <= op_alu8 || op_shift || op_in || op_not;
			o_out   <= t_i3 && (opc3 == `PAT_OP_OUT);
			o_test  <= t_i0 && (opc0 == `PAT_OP_TEST);
			o_bf    <= t_i8 && (opc8 == `PAT_OP_BF);
			o_call  <= t_i8 && (opc8 == `PAT_OP_CALL);
			o_ret   <= t_i0 && (opc0 == `PAT_OP_RETURN);
		end
	end

	always_ff @(posedge clk)
	begin
		o_alu_op <= alu_op;
		o_a      <= i_rd_a;
		o_b      <= b_sel;
		o_rd     <= rn;
		o_cond   <= cond;
		o_offset <= imm8;
	end

endmodule

/* hw/pat_regfile.sv */
`timescale 1ns/10ps
`include "pat_defs.svh"

module pat_regfile
(
	input  logic            clk,
	input  pat_pkg::radr_t  i_adr_a,     // Rn port
	input  pat_pkg::radr_t  i_adr_b,     // second operand port
	input  pat_pkg::radr_t  i_wr_adr,
	input  logic            i_wr,
	input  pat_pkg::data_t  i_wr_data,
	output pat_pkg::data_t  o_data_a,
	output pat_pkg::data_t  o_data_b
);

	localparam int depth = 1 << `PAT_R_ADR_WIDTH;   // eight words

	pat_pkg::data_t mem [depth];

	// asynchronous reads
	assign o_data_a = mem[i_adr_a];
	assign o_data_b = mem[i_adr_b];

	// write lands on the commit edge
	always_ff @(posedge clk)
	begin
		if (i_wr)
			mem[i_wr_adr] <= i_wr_data;
	end

endmodule

/* hw/pat_alu.sv */
`timescale 1ns/10ps
`include "pat_defs.svh"

module pat_alu
(
	input  pat_pkg::alu_op_t  i_op,
	input  pat_pkg::data_t    i_a,    // Rn value
	input  pat_pkg::data_t    i_b,    // immediate, register or port
	output pat_pkg::data_t    o_y
);

	localparam pat_pkg::data_t ones = '1;

	logic [2:0]      amt;        // 1..4
	logic            sub;
	pat_pkg::data_t  b_in;
	pat_pkg::data_t  addsub_y, logic_y, shift_y;
	pat_pkg::data_t  fill_lo, fill_hi;

	// ================================================================
	// add/sub path, one adder with inverted b and carry in
	// ================================================================
	assign sub      = (i_op == pat_pkg::ALU_SUB);
	assign b_in     = sub ? ~i_b : i_b;
	assign addsub_y = i_a + b_in + pat_pkg::data_t'(sub);   // wraps mod 256

	// logic path
	always_comb
	begin
		case (i_op)
			pat_pkg::ALU_OR:  logic_y = i_a | i_b;
			pat_pkg::ALU_AND: logic_y = i_a & i_b;
			pat_pkg::ALU_NOT: logic_y = ~i_a;
			default:          logic_y = i_b;   // pass b for ldi and in
		endcase
	end

	// ================================================================
	// shifter, amount from the two low bits of b plus one
	// ================================================================
	assign amt     = {1'b0, i_b[1:0]} + 3'd1;
	assign fill_lo = ~(ones << amt);   // ones in the vacated low bits
	assign fill_hi = ~(ones >> amt);   // ones in the vacated high bits

	always_comb
	begin
		case (i_op)
			pat_pkg::ALU_SHLZ: shift_y = i_a << amt;
			pat_pkg::ALU_SHLO: shift_y = (i_a << amt) | fill_lo;
			pat_pkg::ALU_SHRZ: shift_y = i_a >> amt;
			default:           shift_y = (i_a >> amt) | fill_hi;   // asr, always fills ones
		endcase
	end

	// result select
	always_comb
	begin
		case (i_op)
			pat_pkg::ALU_ADD, pat_pkg::ALU_SUB:   o_y = addsub_y;
			pat_pkg::ALU_SHLZ, pat_pkg::ALU_SHLO,
			pat_pkg::ALU_SHRZ, pat_pkg::ALU_ASR:  o_y = shift_y;
			default:                              o_y = logic_y;
		endcase
	end

endmodule

/* hw/pat_commit.sv */
`timescale 1ns/10ps
`include "pat_defs.svh"

module pat_commit
(
	input  logic            clk,
	input  logic            reset,
	input  pat_pkg::data_t  i_y,             // alu result
	input  pat_pkg::data_t  i_a,             // Rn value, for out and test
	input  pat_pkg::radr_t  i_rd,
	input  logic [1:0]      i_cond,
	input  logic            i_wr,
	input  logic            i_out,
	input  logic            i_test,
	input  logic            i_bf,
	input  logic            i_call,
	input  logic            i_ret,
	input  pat_pkg::data_t  i_offset,
	output logic            o_wr,
	output pat_pkg::radr_t  o_wr_adr,
	output pat_pkg::data_t  o_wr_data,
	output pat_pkg::data_t  o_out,
	output logic            o_out_wr,        // one pulse per out
	output logic            o_jump_forward,  // bf or call, to pc
	output logic            o_jump_return,
	output logic            o_call,
	output pat_pkg::data_t  o_offset,
	output logic            o_jump
);

	localparam int shadow_w = $clog2(`PAT_JUMP_SHADOW + 1);
	localparam logic [shadow_w-1:0] shadow_len = shadow_w'(`PAT_JUMP_SHADOW);

	logic                 z, n;       // only test updates these
	logic                 cond_ok;
	logic                 exec;       // instruction takes effect
	logic                 take;       // taken jump of any kind
	logic [shadow_w-1:0]  shadow;     // squashed slots still to come

	always_comb
	begin
		case (i_cond)
			`PAT_COND_Z:  cond_ok = z;
			`PAT_COND_NZ: cond_ok = !z;
			`PAT_COND_N:  cond_ok = n;
			default:      cond_ok = 1'b1;
		endcase
	end

	assign exec = cond_ok && (shadow == '0);
	assign take = exec && (i_bf || i_call || i_ret);

	// register write goes straight to the file, written on this edge
	assign o_wr      = exec && i_wr;
	assign o_wr_adr  = i_rd;
	assign o_wr_data = i_y;

	// ================================================================
	// E2 commit registers
	// ================================================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			z <= 1'b0;
			n <= 1'b0;
			shadow <= '0;
			o_out <= '0;
			o_out_wr <= 1'b0;
			o_jump_forward <= 1'b0;
			o_jump_return <= 1'b0;
			o_call <= 1'b0;
			o_jump <= 1'b0;
		end
		else
		begin
			o_out_wr <= exec && i_out;
			o_jump_forward <= exec && (i_bf || i_call);   // call branches like bf
			o_jump_return <= exec && i_ret;
			o_call <= exec && i_call;   // pc latches the link
			o_jump <= take;
			if (take)
				shadow <= shadow_len;   // kill the three already in flight
			else if (shadow != '0)
				shadow <= shadow - 1'b1;
			if (exec && i_test)
			begin
				z <= (i_a == '0);
				n <= i_a[`PAT_D_WIDTH-1];
			end
			if (exec && i_out)
				o_out <= i_a;
		end
	end

	// distance follows the jump pulse to the pc
	always_ff @(posedge clk)
		o_offset <= i_offset;

endmodule

/* hw/pat_pc.sv */
`timescale 1ns/10ps
`include "pat_defs.svh"

module pat_pc
(
	input  logic             clk,
	input  logic             reset,
	input  logic             i_jump_forward,   // bf or call
	input  logic             i_jump_return,
	input  logic             i_call,           // latch link register
	input  pat_pkg::data_t   i_offset,         // signed distance
	output pat_pkg::iaddr_t  o_pc
);

	localparam pat_pkg::iaddr_t call_adjust = `PAT_CALL_ADJUST;

	pat_pkg::iaddr_t pc;
	pat_pkg::iaddr_t lr;           // single-level return address
	pat_pkg::iaddr_t offset_ext;

	// sign extend imm8 to the address width
	assign offset_ext = {{(`PAT_I_ADR_WIDTH - `PAT_D_WIDTH){i_offset[`PAT_D_WIDTH-1]}},
		i_offset};

	// ================================================================
	// program counter
	// ================================================================
	always_ff @(posedge clk)
	begin
		if (reset)
			pc <= '0;
		else if (i_jump_forward)
			pc <= pc + offset_ext;   // relative to the slot three past the jump
		else if (i_jump_return)
			pc <= lr;
		else
			pc <= pc + 1'b1;
	end

	// pc is three ahead of the call here, the link points one past it
	always_ff @(posedge clk)
	begin
		if (i_call)
			lr <= pc - call_adjust;
	end

	assign o_pc = pc;

endmodule

/* hw/pat_core.sv */
`timescale 1ns/10ps
`include "pat_defs.svh"

module pat_core
(
	input  logic             clk,
	input  logic             reset,
	input  pat_pkg::instr_t  i_instruction,   // word at o_pc
	input  pat_pkg::data_t   i_in0,
	input  pat_pkg::data_t   i_in1,
	input  pat_pkg::data_t   i_in2,
	output pat_pkg::iaddr_t  o_pc,
	output logic             o_jump,
	output pat_pkg::data_t   o_out,
	output logic             o_out_wr
);

	// register file ports
	pat_pkg::radr_t    rd_adr_a, rd_adr_b, wr_adr;
	pat_pkg::data_t    rd_a, rd_b, wr_data;
	logic              wr;

	// ================================================================
	// decode to commit
	// ================================================================
	pat_pkg::alu_op_t  alu_op;
	pat_pkg::data_t    a, b, y, offset;
	pat_pkg::radr_t    rd;
	logic [1:0]        cond;
	logic              d_wr, d_out, d_test, d_bf, d_call, d_ret;

	// commit to pc
	logic              jump_forward, jump_return, call;
	pat_pkg::data_t    pc_offset;

	pat_decode u_decode (.clk(clk), .reset(reset), .i_instruction(i_instruction),
		.i_in0(i_in0), .i_in1(i_in1), .i_in2(i_in2), .i_rd_a(rd_a), .i_rd_b(rd_b),
		.o_rd_adr_a(rd_adr_a), .o_rd_adr_b(rd_adr_b), .o_alu_op(alu_op), .o_a(a), .o_b(b),
		.o_rd(rd), .o_cond(cond), .o_wr(d_wr), .o_out(d_out), .o_test(d_test),
		.o_bf(d_bf), .o_call(d_call), .o_ret(d_ret), .o_offset(offset));

	pat_regfile u_regfile (.clk(clk), .i_adr_a(rd_adr_a), .i_adr_b(rd_adr_b),
		.i_wr_adr(wr_adr), .i_wr(wr), .i_wr_data(wr_data), .o_data_a(rd_a),
		.o_data_b(rd_b));

	pat_alu u_alu (.i_op(alu_op), .i_a(a), .i_b(b), .o_y(y));

	pat_commit u_commit (.clk(clk), .reset(reset), .i_y(y), .i_a(a), .i_rd(rd),
		.i_cond(cond), .i_wr(d_wr), .i_out(d_out), .i_test(d_test), .i_bf(d_bf),
		.i_call(d_call), .i_ret(d_ret), .i_offset(offset), .o_wr(wr), .o_wr_adr(wr_adr),
		.o_wr_data(wr_data), .o_out(o_out), .o_out_wr(o_out_wr),
		.o_jump_forward(jump_forward), .o_jump_return(jump_return), .o_call(call),
		.o_offset(pc_offset), .o_jump(o_jump));

	pat_pc u_pc (.clk(clk), .reset(reset), .i_jump_forward(jump_forward),
		.i_jump_return(jump_return), .i_call(call), .i_offset(pc_offset), .o_pc(o_pc));

endmodule

/* bench/pat_tb.sv */
`timescale 1ns/10ps
`include "pat_defs.svh"

module pat_tb;

	localparam int num_tests    = 6;
	localparam int prog_len     = 16;    // words per program
	localparam int max_outs     = 4;
	localparam int reset_cycles = 5;
	localparam int run_cycles   = 40;    // feed window per test
	localparam int cycle_limit  = num_tests * (reset_cycles + run_cycles) + 30;   // 300

	localparam logic [1:0] cz  = `PAT_COND_Z;
	localparam logic [1:0] cnz = `PAT_COND_NZ;
	localparam logic [1:0] cn  = `PAT_COND_N;
	localparam logic [1:0] al  = `PAT_COND_AL;
	localparam pat_pkg::instr_t nop = `PAT_INSTR_NOP;

	logic             clk = 1'b0;
	logic             reset;
	pat_pkg::instr_t  i_instruction;
	pat_pkg::data_t   i_in0, i_in1, i_in2;
	pat_pkg::iaddr_t  o_pc;
	logic             o_jump;
	pat_pkg::data_t   o_out;
	logic             o_out_wr;

	// ==================================================================
	// test table with one row per test
	// ==================================================================
	string            t_name  [num_tests];
	pat_pkg::instr_t  t_prog  [num_tests][prog_len];
	pat_pkg::data_t   t_exp   [num_tests][max_outs];
	int               t_count [num_tests];    // outputs expected
	int               t_jumps [num_tests];    // o_jump pulses expected
	int               t_end_pc [num_tests];   // o_pc at the end of the feed window

	pat_pkg::data_t   got [$];                // collected o_out values
	int               jump_seen;
	int               seed;
	int               cycle_count  = 0;
	int               value_errors = 0;
	int               count_errors = 0;
	logic             collecting   = 1'b0;

	pat_core uut
	(
		.clk(clk), .reset(reset), .i_instruction(i_instruction),
		.i_in0(i_in0), .i_in1(i_in1), .i_in2(i_in2),
		.o_pc(o_pc), .o_jump(o_jump), .o_out(o_out), .o_out_wr(o_out_wr)
	);

	always #5 clk = ~clk;   // 10 ns period

	// Rn | reserved | cond | reserved | i8 op | imm8
	function automatic pat_pkg::instr_t i8_word(input int rn, input logic [1:0] cond,
		input logic [3:0] op, input int imm);
		return {3'(rn), 5'b0, cond, 1'b0, op, 8'(imm)};
	endfunction

	function automatic pat_pkg::instr_t i3_word(input int rn, input logic [1:0] cond,
		input logic [3:0] op, input int imm);
		return i8_word(rn, cond, `PAT_PREFIX, {op, 1'b0, 3'(imm)});   // op in imm8[7:4]
	endfunction

	function automatic pat_pkg::instr_t i0_word(input int rn, input logic [1:0] cond,
		input logic [3:0] op);
		return i8_word(rn, cond, `PAT_PREFIX, {`PAT_PREFIX, op});
	endfunction

	function automatic pat_pkg::instr_t ldi_word(input int rn, input int imm);
		return i8_word(rn, al, `PAT_OP_LDI, imm);
	endfunction

	function automatic pat_pkg::instr_t out_word(input int rn, input logic [1:0] cond);
		return i3_word(rn, cond, `PAT_OP_OUT, 0);
	endfunction

	// program word at pc and nop past the end
	function automatic pat_pkg::instr_t fetch(input int t, input pat_pkg::iaddr_t pc);
		return (pc < prog_len) ? t_prog[t][pc] : nop;
	endfunction

	task automatic load_table();
		t_name[0] = "alu_imm";   // ldi, immediate forms, not
		t_prog[0] = '{ldi_word(1, 8'h3c), ldi_word(2, 8'h20),
			i8_word(1, al, `PAT_OP_ADDI, 8'hd9), i8_word(2, al, `PAT_OP_SUBI, 8'h31),
			out_word(1, al), out_word(2, al), i8_word(1, al, `PAT_OP_ORI, 8'h82),
			i8_word(2, al, `PAT_OP_ANDI, 8'h5a), i0_word(1, al, `PAT_OP_NOT),
			out_word(2, al), out_word(1, al), nop, nop, nop, nop, nop};
		t_exp[0] = '{8'h3c + 8'hd9, 8'h20 - 8'h31, (8'h20 - 8'h31) & 8'h5a,
			~((8'h3c + 8'hd9) | 8'h82)};
		t_name[1] = "reg_shift";   // register forms and each shift kind
		t_prog[1] = '{ldi_word(1, 8'h96), ldi_word(2, 8'h02), ldi_word(3, 8'h5a),
			ldi_word(4, 8'h71), i8_word(1, al, `PAT_OP_ADDR, 2),
			i8_word(3, al, `PAT_OP_SUBR, 2), i3_word(1, al, `PAT_OP_SHLZI, 1),
			i3_word(3, al, `PAT_OP_SHRZR, 2), i3_word(4, al, `PAT_OP_SHLOR, 2),
			i3_word(2, al, `PAT_OP_ASRI, 2), i8_word(1, al, `PAT_OP_ORR, 3),
			i8_word(4, al, `PAT_OP_ANDR, 2), out_word(1, al), out_word(4, al),
			out_word(3, al), out_word(2, al)};
		t_exp[1] = '{((8'h96 + 8'h02) << 2) | ((8'h5a - 8'h02) >> 3),
			((8'h71 << 3) | 8'h07) & ((8'h02 >> 3) | 8'he0),
			(8'h5a - 8'h02) >> 3, (8'h02 >> 3) | 8'he0};
		t_name[2] = "in_ports";
		t_prog[2] = '{i3_word(1, al, `PAT_OP_IN, 1), i3_word(2, al, `PAT_OP_IN, 2),
			i3_word(3, al, `PAT_OP_IN, 4), i3_word(4, al, `PAT_OP_IN, 0),
			out_word(1, al), out_word(2, al), out_word(3, al), out_word(4, al),
			nop, nop, nop, nop, nop, nop, nop, nop};
		t_exp[2] = '{i_in0, i_in1, i_in2, i_in0};
		t_name[3] = "test_cond";   // z then n with conditional outs and a skipped ldi
		t_prog[3] = '{ldi_word(1, 8'h00), ldi_word(2, 8'h85), ldi_word(3, 8'h11),
			ldi_word(4, 8'h22), i0_word(1, al, `PAT_OP_TEST), out_word(3, cz),
			out_word(4, cnz), out_word(4, cn), i0_word(2, al, `PAT_OP_TEST),
			out_word(3, cz), out_word(4, cnz), out_word(2, cn),
			i8_word(4, cz, `PAT_OP_LDI, 8'h33), nop, out_word(4, al), nop};
		t_exp[3] = '{8'h11, 8'h22, 8'h85, 8'h22};
		t_name[4] = "branch";   // untaken bf.z then bf over 0xee markers to slot 9
		t_prog[4] = '{ldi_word(1, 8'hee), ldi_word(2, 8'h42),
			i8_word(0, cz, `PAT_OP_BF, 5), out_word(2, al), i8_word(0, al, `PAT_OP_BF, 2),
			out_word(1, al), out_word(1, al), out_word(1, al), out_word(1, al),
			ldi_word(3, 8'h37), nop, out_word(3, al), nop, nop, nop, nop};
		t_exp[4] = '{8'h42, 8'h37, 8'h00, 8'h00};
		t_name[5] = "call_return";   // call to 10 and return to 5 then bf off the end
		t_prog[5] = '{ldi_word(1, 8'h11), ldi_word(2, 8'h22), ldi_word(3, 8'h33),
			out_word(1, al), i8_word(0, al, `PAT_OP_CALL, 3), out_word(3, al),
			i8_word(0, al, `PAT_OP_BF, 8'h10), out_word(1, al), out_word(1, al), nop,
			out_word(2, al), i0_word(0, al, `PAT_OP_RETURN), out_word(1, al),
			out_word(1, al), out_word(1, al), nop};
		t_exp[5] = '{8'h11, 8'h22, 8'h33, 8'h00};
		t_count = '{4, 4, 4, 4, 2, 3};
		t_jumps = '{0, 0, 0, 0, 1, 3};
		// one step per edge plus the net jump displacement
		// bf 7 to 9 adds 1 in branch
		// call 7 to 10 adds 2, return 14 to 5 takes 10 and bf 9 to 25 adds 15 in call_return
		t_end_pc = '{run_cycles, run_cycles, run_cycles, run_cycles, run_cycles + 1,
			run_cycles + 2 - 10 + 15};
	endtask

	// pulses are one cycle wide, so the falling edge sees each once
	always @(negedge clk)
	begin
		if (collecting && o_out_wr)
			got.push_back(o_out);
		if (collecting && o_jump)
			jump_seen++;
	end

	task automatic check_results(input int t);
		assert (got.size() == t_count[t]) else begin
			count_errors++;
			$display("mismatch %s out count: expected %0d, actual %0d", t_name[t],
				t_count[t], got.size());
		end
		for (int k = 0; k < t_count[t] && k < got.size(); k++)
			assert (got[k] == t_exp[t][k]) else begin
				value_errors++;
				$display("mismatch %s out[%0d]: expected %h, actual %h", t_name[t], k,
					t_exp[t][k], got[k]);
			end
		assert (jump_seen == t_jumps[t]) else begin
			count_errors++;
			$display("mismatch %s jump pulses: expected %0d, actual %0d", t_name[t],
				t_jumps[t], jump_seen);
		end
		assert (o_pc == t_end_pc[t]) else begin
			value_errors++;
			$display("mismatch %s final pc: expected %0d, actual %0d", t_name[t],
				t_end_pc[t], o_pc);
		end
	endtask

	task automatic run_test(input int t);
		got.delete();
		jump_seen = 0;
		reset = 1'b1;
		i_instruction = fetch(t, '0);   // pc sits at 0 through reset
		repeat (reset_cycles) @(posedge clk);
		#1;
		reset = 1'b0;
		collecting = 1'b1;
		repeat (run_cycles)
		begin
			@(posedge clk);
			#1;
			i_instruction = fetch(t, o_pc);   // word for the new pc
		end
		collecting = 1'b0;
		check_results(t);
	endtask

	// ==================================================================
	// main sequence and cycle limit
	// ==================================================================
	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= cycle_limit)
		begin
			$display("run did not finish within %0d cycles", cycle_limit);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	initial
	begin
		seed = 23212;
		reset = 1'b1;
		i_instruction = nop;
		i_in0 = 8'($random(seed));
		i_in1 = 8'($random(seed));
		i_in2 = 8'($random(seed));
		load_table();
		for (int t = 0; t < num_tests; t++)
			run_test(t);
		$display("errors: %0d wrong values, %0d wrong counts", value_errors, count_errors);
		if (value_errors + count_errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+include
hw/pat_pkg.sv
hw/pat_decode.sv
hw/pat_regfile.sv
hw/pat_alu.sv
hw/pat_commit.sv
hw/pat_pc.sv
hw/pat_core.sv
bench/pat_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the core with its testbench, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
	--top-module pat_tb -o pat_sim \
	&& ./obj_dir/pat_sim | tee /dev/stderr | grep -qx "ALL TESTS PASSED" \
	&& { echo "PASS"; exit 0; } \
	|| { echo "FAIL"; exit 1; }
